// File: Makefile
TOP = afu_main_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module afu_main

sim:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: src.f
+incdir+src
src/tlp_pkg.sv
src/route_pkg.sv
src/stream_pipe.sv
src/pfvf_router.sv
src/loopback_afu.sv
src/afu_main.sv
tests/afu_main_tb.sv

// File: src/afu_cfg.svh
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

// Build-time sizing of the accelerator region

// Number of exerciser ports behind the function router
`define AFU_NUM_PORTS 3

// Width of every packet word on the host and port streams
`define AFU_WORD_W 64

// Scratch words held by each loopback exerciser
// The request address field is sized from this value
`define AFU_MEM_DEPTH 16

// Register stages on the receive and on the transmit host stream
`define AFU_PL_DEPTH 1

// The end-to-end read latency grows by two cycles for every
// extra pipeline stage, since both host streams use this depth

`endif

// File: src/afu_main.sv
`timescale 1ns/10ps

`include "afu_cfg.svh"

module afu_main #(
   parameter route_pkg::rtable_t rtable = route_pkg::DEFAULT_RTABLE
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [`AFU_NUM_PORTS-1:0] port_rst_n,

   // Host receive stream carries request words
   input  logic                      rx_valid,
   input  tlp_pkg::tlp_word_t        rx_data,

   // Host transmit stream carries completion words
   output logic                      tx_valid,
   output tlp_pkg::tlp_word_t        tx_data,

   // Strobe for a request that no table entry claimed
   output logic                      unrouted
);

   import tlp_pkg::*;

   // Request stream between the receive pipeline and the router
   logic                                req_valid;
   tlp_word_t                           req_data;

   // Router to exerciser requests and exerciser completions
   logic      [`AFU_NUM_PORTS-1:0]      port_req_valid;
   tlp_word_t                           port_req_data;
   logic      [`AFU_NUM_PORTS-1:0]      cpl_valid;
   tlp_word_t [`AFU_NUM_PORTS-1:0]      cpl_data;

   // Merged completions on their way to the transmit pipeline
   logic                                merged_valid;
   tlp_word_t                           merged_data;

   // ========================================
   // Port reset synchronization
   // ========================================

   logic                      rst_n_q1;
   logic [`AFU_NUM_PORTS-1:0] port_rst_n_q1;
   logic [`AFU_NUM_PORTS-1:0] port_rst_n_q2;

   // Each port reset passes two flops and is held by the global reset too
   always_ff @(posedge clk) begin
      rst_n_q1      <= rst_n;
      port_rst_n_q1 <= port_rst_n;
      port_rst_n_q2 <= port_rst_n_q1 & {`AFU_NUM_PORTS{rst_n_q1}};
   end

   // ========================================
   // Host pipelines and router
   // ========================================

   stream_pipe #(.depth(`AFU_PL_DEPTH)) rx_pipe (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (rx_valid),
      .in_data   (rx_data),
      .out_valid (req_valid),
      .out_data  (req_data)
   );

   pfvf_router #(.rtable(rtable)) router_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .req_valid      (req_valid),
      .req_data       (req_data),
      .port_req_valid (port_req_valid),
      .port_req_data  (port_req_data),
      .unrouted       (unrouted),
      .cpl_valid      (cpl_valid),
      .cpl_data       (cpl_data),
      .merged_valid   (merged_valid),
      .merged_data    (merged_data)
   );

   stream_pipe #(.depth(`AFU_PL_DEPTH)) tx_pipe (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (merged_valid),
      .in_data   (merged_data),
      .out_valid (tx_valid),
      .out_data  (tx_data)
   );

   // ========================================
   // Exercisers
   // ========================================

   // One loopback engine per port, each under its own synchronized reset
   for (genvar p = 0; p < `AFU_NUM_PORTS; p++) begin : port_afu
      loopback_afu afu_i (
         .clk       (clk),
         .rst_n     (port_rst_n_q2[p]),
         .req_valid (port_req_valid[p]),
         .req_data  (port_req_data),
         .cpl_valid (cpl_valid[p]),
         .cpl_data  (cpl_data[p])
      );
   end

endmodule

// File: src/loopback_afu.sv
`timescale 1ns/10ps

`include "afu_cfg.svh"

module loopback_afu (
   input  logic               clk,
   // Port reset already combined with the global reset
   input  logic               rst_n,
   input  logic               req_valid,
   input  tlp_pkg::tlp_word_t req_data,
   output logic               cpl_valid,
   output tlp_pkg::tlp_word_t cpl_data
);

   import tlp_pkg::*;

   // Scratch memory addressed by the request's addr field
   logic [DATA_W-1:0] mem [`AFU_MEM_DEPTH];

   // Request decode through the request view
   logic      wr_req;
   logic      rd_req;
   tlp_word_t cpl_next;

   assign wr_req = req_valid && req_data.req.is_write;
   assign rd_req = req_valid && !req_data.req.is_write;

   // ========================================
   // Scratch memory
   // ========================================

   // The whole memory clears while the port is held in reset
   // Writes land at the same edge where their strobe is seen
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < `AFU_MEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_req) begin
         mem[req_data.req.addr] <= req_data.req.data;
      end
   end

   // ========================================
   // Completion build
   // ========================================

   // The reply is assembled through the completion view
   // Function numbers and tag come back exactly as the host sent them
   always_comb begin
      cpl_next            = '0;
      cpl_next.cpl.is_cpl = 1'b1;
      cpl_next.cpl.pf     = req_data.req.pf;
      cpl_next.cpl.vf     = req_data.req.vf;
      cpl_next.cpl.tag    = req_data.req.tag;
      cpl_next.cpl.data   = mem[req_data.req.addr];
   end

   // A read answers one cycle after its strobe
   // Strobes that arrive during port reset get no answer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cpl_valid <= 1'b0;
      end else begin
         cpl_valid <= rd_req;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req) begin
         cpl_data <= cpl_next;
      end
   end

   // The router only forwards host requests, so a completion arriving here
   // means the host stream or the routing is broken upstream
   a_no_cpl_in: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid |-> !req_data.req.is_cpl)
      else $error("loopback_afu received a completion word");

endmodule

// File: src/pfvf_router.sv
`timescale 1ns/10ps

`include "afu_cfg.svh"

module pfvf_router #(
   parameter route_pkg::rtable_t rtable = route_pkg::DEFAULT_RTABLE
) (
   input  logic                                     clk,
   input  logic                                     rst_n,

   // Host request stream after the receive pipeline
   input  logic                                     req_valid,
   input  tlp_pkg::tlp_word_t                       req_data,

   // Request strobes to the exercisers share one data word
   output logic [`AFU_NUM_PORTS-1:0]                port_req_valid,
   output tlp_pkg::tlp_word_t                       port_req_data,
   output logic                                     unrouted,

   // Completions coming back from the exercisers
   input  logic [`AFU_NUM_PORTS-1:0]                cpl_valid,
   input  tlp_pkg::tlp_word_t [`AFU_NUM_PORTS-1:0]  cpl_data,

   // Merged completion stream toward the transmit pipeline
   output logic                                     merged_valid,
   output tlp_pkg::tlp_word_t                       merged_data
);

   import tlp_pkg::*;

   // ========================================
   // Request side
   // ========================================

   // Ports whose table entry claims the current request word
   logic [`AFU_NUM_PORTS-1:0] hit_vec;

   // Every entry is compared in parallel against the request's function
   // With distinct entries at most one of them can match
   always_comb begin
      hit_vec = '0;
      for (int i = 0; i < `AFU_NUM_PORTS; i++) begin
         if (req_data.req.pf == rtable[i].pf && req_data.req.vf == rtable[i].vf) begin
            hit_vec[rtable[i].port] = 1'b1;
         end
      end
   end

   // The matching port gets a one-hot strobe one cycle after the request
   // A request that misses every entry raises unrouted in the same slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         port_req_valid <= '0;
         unrouted       <= 1'b0;
      end else begin
         port_req_valid <= req_valid ? hit_vec : '0;
         unrouted       <= req_valid && (hit_vec == '0);
      end
   end

   // One registered copy of the word fans out to all ports
   always_ff @(posedge clk) begin
      if (req_valid) begin
         port_req_data <= req_data;
      end
   end

   // ========================================
   // Completion side
   // ========================================

   // Exercisers answer after a fixed delay, so completions never collide
   // and the merge reduces to picking the one valid port
   always_comb begin
      merged_data = '0;
      for (int i = 0; i < `AFU_NUM_PORTS; i++) begin
         if (cpl_valid[i]) begin
            merged_data = cpl_data[i];
         end
      end
   end

   assign merged_valid = |cpl_valid;

   // ========================================
   // Checks
   // ========================================

   // A second completion in one cycle would be dropped by the merge
   a_cpl_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(cpl_valid))
      else $error("pfvf_router saw more than one completion in a cycle");

   // Overlapping table entries would deliver one word to several ports
   a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(port_req_valid))
      else $error("pfvf_router strobed more than one port");

   // A word is either delivered or flagged, never both
   a_unrouted_excl: assert property (@(posedge clk) disable iff (!rst_n)
      unrouted |-> (port_req_valid == '0))
      else $error("pfvf_router flagged a word it also delivered");

endmodule

// File: src/route_pkg.sv
`include "afu_cfg.svh"

package route_pkg;

   // Index of one exerciser port behind the router
   typedef logic [1:0] port_idx_t;

   // One routing entry names a function and the port that serves it
   typedef struct packed {
      logic [tlp_pkg::PF_W-1:0] pf;
      logic [tlp_pkg::VF_W-1:0] vf;
      port_idx_t                port;
   } rtable_entry_t;

   // Entry i describes the function served by port i
   typedef rtable_entry_t [`AFU_NUM_PORTS-1:0] rtable_t;

   // Default mapping of functions to exercisers
   // pf0/vf1 and pf0/vf2 sit on the first two ports, pf1/vf0 on the last
   localparam rtable_t DEFAULT_RTABLE = '{
      2: '{pf: 3'd1, vf: 5'd0, port: 2'd2},
      1: '{pf: 3'd0, vf: 5'd2, port: 2'd1},
      0: '{pf: 3'd0, vf: 5'd1, port: 2'd0}
   };

endpackage

// File: src/stream_pipe.sv
`timescale 1ns/10ps

`include "afu_cfg.svh"

module stream_pipe #(
   parameter int depth = 1
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  logic [`AFU_WORD_W-1:0] in_data,
   output logic                   out_valid,
   output logic [`AFU_WORD_W-1:0] out_data
);

   // Stage 0 takes the input and the last stage drives the output
   logic [depth-1:0]       vld_q;
   logic [`AFU_WORD_W-1:0] dat_q [depth];

   // Valid strobes shift one stage per clock and clear on reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else begin
         vld_q[0] <= in_valid;
         for (int i = 1; i < depth; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   // Data words follow their strobes through the same stages
   always_ff @(posedge clk) begin
      dat_q[0] <= in_data;
      for (int i = 1; i < depth; i++) begin
         dat_q[i] <= dat_q[i-1];
      end
   end

   assign out_valid = vld_q[depth-1];
   assign out_data  = dat_q[depth-1];

   // Downstream logic must never see an unknown strobe once reset is gone
   a_out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(out_valid))
      else $error("stream_pipe out_valid is unknown after reset");

endmodule

// File: src/tlp_pkg.sv
`include "afu_cfg.svh"

package tlp_pkg;

   // Field widths shared by both views of a packet word
   localparam int PF_W   = 3;
   localparam int VF_W   = 5;
   localparam int TAG_W  = 8;
   localparam int DATA_W = 32;
   localparam int ADDR_W = $clog2(`AFU_MEM_DEPTH);

   // Padding that fills each view out to the full word
   localparam int REQ_RSVD_W = `AFU_WORD_W - 2 - PF_W - VF_W - TAG_W - ADDR_W - DATA_W;
   localparam int CPL_RSVD_W = `AFU_WORD_W - 2 - PF_W - VF_W - TAG_W - DATA_W;

   // Host request as it arrives on the receive stream
   typedef struct packed {
      logic                  is_cpl;
      logic                  is_write;
      logic [PF_W-1:0]       pf;
      logic [VF_W-1:0]       vf;
      logic [TAG_W-1:0]      tag;
      logic [REQ_RSVD_W-1:0] rsvd;
      logic [ADDR_W-1:0]     addr;
      logic [DATA_W-1:0]     data;
   } tlp_req_t;

   // Completion as it leaves on the transmit stream
   // The single bit after is_cpl sits where a request keeps is_write
   typedef struct packed {
      logic                  is_cpl;
      logic                  rsvd_hi;
      logic [PF_W-1:0]       pf;
      logic [VF_W-1:0]       vf;
      logic [TAG_W-1:0]      tag;
      logic [CPL_RSVD_W-1:0] rsvd_lo;
      logic [DATA_W-1:0]     data;
   } tlp_cpl_t;

   // One packet word seen either as a request or as a completion
   typedef union packed {
      tlp_req_t req;
      tlp_cpl_t cpl;
   } tlp_word_t;

endpackage

// File: tests/afu_main_tb.sv
`timescale 1ns/10ps

`include "afu_cfg.svh"

module afu_main_tb;

   import tlp_pkg::*;

   // Completions leave four cycles after the read, unrouted flags after two
   localparam int RD_LAT      = 4;
   localparam int UNR_LAT     = 2;
   localparam int CYCLE_LIMIT = 2000;

   logic                      clk;
   logic                      rst_n;
   logic [`AFU_NUM_PORTS-1:0] port_rst_n;
   logic                      rx_valid;
   tlp_word_t                 rx_data;
   logic                      tx_valid;
   tlp_word_t                 tx_data;
   logic                      unrouted;

   // Shadow copy of every scratch memory, updated as requests are issued
   logic [DATA_W-1:0] shadow [`AFU_NUM_PORTS][`AFU_MEM_DEPTH];

   // Pending responses, each stamped with the cycle of its request
   int                exp_cyc_q [$];
   tlp_word_t         exp_cpl_q [$];
   int                unr_cyc_q [$];

   // What the outputs must show in the current cycle
   logic              exp_tx_valid;
   tlp_word_t         exp_tx_data;
   logic              exp_unrouted;

   logic [TAG_W-1:0]  tag_ctr;
   int                cyc;
   int                err_cnt;

   afu_main dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .port_rst_n (port_rst_n),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .tx_valid   (tx_valid),
      .tx_data    (tx_data),
      .unrouted   (unrouted)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // The run cannot outlast the cycle limit
   initial begin
      wait (cyc == CYCLE_LIMIT);
      $display("Timeout after %0d cycles, the test sequence never finished", cyc);
      $display("Simulation failed");
      $finish;
   end

   // ========================================
   // Reference model
   // ========================================

   // Functions served by each port, as the default routing table assigns them
   function automatic logic [PF_W-1:0] pf_of(input int port);
      return (port == 2) ? PF_W'(1) : PF_W'(0);
   endfunction

   function automatic logic [VF_W-1:0] vf_of(input int port);
      case (port)
         0: return VF_W'(1);
         1: return VF_W'(2);
         default: return VF_W'(0);
      endcase
   endfunction

   function automatic tlp_word_t make_req(input logic wr, input logic [PF_W-1:0] pf,
                                          input logic [VF_W-1:0] vf,
                                          input logic [TAG_W-1:0] tag,
                                          input logic [ADDR_W-1:0] addr,
                                          input logic [DATA_W-1:0] data);
      tlp_word_t w;
      w              = '0;
      w.req.is_write = wr;
      w.req.pf       = pf;
      w.req.vf       = vf;
      w.req.tag      = tag;
      w.req.addr     = addr;
      w.req.data     = data;
      return w;
   endfunction

   // Expectations move to the compare signals half a cycle before the check edge
   always @(negedge clk) begin
      exp_tx_valid = 1'b0;
      exp_tx_data  = '0;
      exp_unrouted = 1'b0;
      if (exp_cyc_q.size() > 0 && exp_cyc_q[0] + RD_LAT == cyc) begin
         exp_tx_valid = 1'b1;
         exp_tx_data  = exp_cpl_q.pop_front();
         void'(exp_cyc_q.pop_front());
      end
      if (unr_cyc_q.size() > 0 && unr_cyc_q[0] + UNR_LAT == cyc) begin
         exp_unrouted = 1'b1;
         void'(unr_cyc_q.pop_front());
      end
   end

   // ========================================
   // Checks
   // ========================================

   a_tx_valid: assert property (@(posedge clk) disable iff (!rst_n)
      tx_valid == exp_tx_valid)
      else begin
         err_cnt++;
         $display("MISMATCH tx_valid: got %h expected %h", $sampled(tx_valid),
                  $sampled(exp_tx_valid));
      end

   // Checks is_cpl, data, tag and both function numbers in one compare
   a_tx_data: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_valid && exp_tx_valid) |-> (tx_data == exp_tx_data))
      else begin
         err_cnt++;
         $display("MISMATCH tx_data: got %h expected %h", $sampled(tx_data),
                  $sampled(exp_tx_data));
      end

   a_unrouted: assert property (@(posedge clk) disable iff (!rst_n)
      unrouted == exp_unrouted)
      else begin
         err_cnt++;
         $display("MISMATCH unrouted: got %h expected %h", $sampled(unrouted),
                  $sampled(exp_unrouted));
      end

   // ========================================
   // Stimulus
   // ========================================

   // One word on the receive stream, held for a single cycle
   task automatic drive_word(input tlp_word_t w);
      @(posedge clk);
      #1;
      rx_valid = 1'b1;
      rx_data  = w;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         rx_valid = 1'b0;
      end
   endtask

   task automatic write_port(input int port, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
      tag_ctr = tag_ctr + 1'b1;
      drive_word(make_req(1'b1, pf_of(port), vf_of(port), tag_ctr, addr, data));
      shadow[port][addr] = data;
   endtask

   // A read expects the shadow word as it stands when the read is issued
   task automatic read_port(input int port, input logic [ADDR_W-1:0] addr);
      tlp_word_t e;
      tag_ctr = tag_ctr + 1'b1;
      drive_word(make_req(1'b0, pf_of(port), vf_of(port), tag_ctr, addr, '0));
      e            = '0;
      e.cpl.is_cpl = 1'b1;
      e.cpl.pf     = pf_of(port);
      e.cpl.vf     = vf_of(port);
      e.cpl.tag    = tag_ctr;
      e.cpl.data   = shadow[port][addr];
      exp_cyc_q.push_back(cyc);
      exp_cpl_q.push_back(e);
   endtask

   // pf0/vf3 is claimed by no port, so the word must be flagged and dropped
   task automatic send_stray(input logic wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
      tag_ctr = tag_ctr + 1'b1;
      drive_word(make_req(wr, PF_W'(0), VF_W'(3), tag_ctr, addr, data));
      unr_cyc_q.push_back(cyc);
   endtask

   // Holds one port in reset, after which its memory reads as zero
   task automatic reset_port(input int port, input int n);
      @(posedge clk);
      #1;
      rx_valid         = 1'b0;
      port_rst_n[port] = 1'b0;
      repeat (n) @(posedge clk);
      #1;
      port_rst_n[port] = 1'b1;
      for (int a = 0; a < `AFU_MEM_DEPTH; a++) begin
         shadow[port][a] = '0;
      end
      idle(4);
   endtask

   initial begin
      logic [ADDR_W-1:0] addr;
      clk          = 1'b0;
      rst_n        = 1'b0;
      port_rst_n   = '1;
      rx_valid     = 1'b0;
      rx_data      = '0;
      exp_tx_valid = 1'b0;
      exp_tx_data  = '0;
      exp_unrouted = 1'b0;
      tag_ctr      = '0;
      err_cnt      = 0;
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         for (int a = 0; a < `AFU_MEM_DEPTH; a++) begin
            shadow[p][a] = '0;
         end
      end
      void'($urandom(32'h63dc));

      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Quiet period, so both strobes must stay low
      idle(10);

      // Write then read on every port in turn
      for (int i = 0; i < 24; i++) begin
         addr = ADDR_W'($urandom);
         write_port(i % `AFU_NUM_PORTS, addr, $urandom);
         read_port(i % `AFU_NUM_PORTS, addr);
      end
      idle(6);

      // Same address on all ports holds different data
      addr = ADDR_W'($urandom);
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         write_port(p, addr, $urandom);
      end
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         read_port(p, addr);
      end

      // One read per cycle, rotating over the ports
      for (int i = 0; i < 120; i++) begin
         read_port(i % `AFU_NUM_PORTS, ADDR_W'($urandom));
      end
      idle(6);

      // Unclaimed words mixed with reads of the address they aimed at
      for (int i = 0; i < 8; i++) begin
         addr = ADDR_W'($urandom);
         send_stray((i % 2) == 0, addr, $urandom);
         read_port(i % `AFU_NUM_PORTS, addr);
      end
      idle(6);

      // Fill everything, clear port 1 only, then read all of it back
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         for (int a = 0; a < `AFU_MEM_DEPTH; a++) begin
            write_port(p, ADDR_W'(a), $urandom);
         end
      end
      reset_port(1, 5);
      for (int p = 0; p < `AFU_NUM_PORTS; p++) begin
         for (int a = 0; a < `AFU_MEM_DEPTH; a++) begin
            read_port(p, ADDR_W'(a));
         end
      end
      idle(RD_LAT + 4);

      if (exp_cyc_q.size() != 0 || unr_cyc_q.size() != 0) begin
         err_cnt++;
         $display("Missing responses: %0d completions and %0d unrouted flags never came",
                  exp_cyc_q.size(), unr_cyc_q.size());
      end
      $display("Checks finished with %0d errors", err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
